//--- dv/cdb_checker.sv
`timescale 1ns/1ns

module cdb_checker
import rv32i_types::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_valid,
    input  issue_pkt_t issue,
    input  logic       flush,
    input  logic       busy,
    input  cdb_t       cdb,
    input  logic       end_check,
    output int         mismatch_cnt,
    output int         error_cnt,
    output int         pending_cnt,
    output logic       end_done
);

    localparam int NUM_SLOTS   = 2 ** ROB_ADDR_WIDTH;
    // divide and fix-up then one more cycle through the CDB register
    localparam int MIN_LATENCY = NUM_DIV_CYCLES + 2;

    localparam logic [1:0] SLOT_FREE    = 2'd0;
    localparam logic [1:0] SLOT_PENDING = 2'd1;
    localparam logic [1:0] SLOT_DONE    = 2'd2;

    logic [1:0] slot_state [NUM_SLOTS];
    xlen_word_t exp_val    [NUM_SLOTS];
    res_tag_t   exp_tag    [NUM_SLOTS];
    int         acc_cyc    [NUM_SLOTS];
    int         cyc;
    logic       seen_issue;

    // RISC-V M results rounded toward zero
    function automatic xlen_word_t expected_result(input div_funct_t op, input xlen_word_t a,
                                                   input xlen_word_t b);
        logic       ovf;
        xlen_word_t res;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            DIV_OP_DIV: begin
                if (b == '0) begin
                    res = '1;
                end else if (ovf) begin
                    res = a;
                end else begin
                    res = $signed(a) / $signed(b);
                end
            end
            DIV_OP_REM: begin
                if (b == '0) begin
                    res = a;
                end else if (ovf) begin
                    res = '0;
                end else begin
                    res = $signed(a) % $signed(b);
                end
            end
            DIV_OP_DIVU: res = (b == '0) ? '1 : a / b;
            default:     res = (b == '0) ? a : a % b;
        endcase
        return res;
    endfunction

    task automatic check_beat();
        int idx;
        int lat;
        idx = int'(cdb.tag.rob_idx);
        if (slot_state[idx] == SLOT_FREE) begin
            error_cnt++;
            $display("unexpected CDB result at %0t for ROB index %0d, nothing in flight there",
                     $time, idx);
        end else if (slot_state[idx] == SLOT_DONE) begin
            error_cnt++;
            $display("duplicate CDB result at %0t for ROB index %0d", $time, idx);
        end else begin
            // the beat was registered one edge before this sample
            lat = cyc - 1 - acc_cyc[idx];
            if (lat < MIN_LATENCY) begin
                error_cnt++;
                $display("result for ROB index %0d came after only %0d cycles", idx, lat);
            end
            if (cdb.tag !== exp_tag[idx]) begin
                mismatch_cnt++;
                $display("mismatch at %0t: ROB %0d tag %h, expected %h",
                         $time, idx, cdb.tag, exp_tag[idx]);
            end
            if (cdb.rd_v !== exp_val[idx]) begin
                mismatch_cnt++;
                $display("mismatch at %0t: ROB %0d value %08h, expected %08h",
                         $time, idx, cdb.rd_v, exp_val[idx]);
            end
            slot_state[idx] = SLOT_DONE;
        end
    endtask

    // an idle CDB while some lane has finished breaks the one-per-cycle drain
    task automatic check_drain();
        int late_idx;
        late_idx = -1;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (late_idx < 0 && slot_state[i] == SLOT_PENDING
                && cyc - 1 - acc_cyc[i] >= MIN_LATENCY) begin
                late_idx = i;
            end
        end
        if (late_idx >= 0) begin
            error_cnt++;
            $display("CDB idle at %0t while the result for ROB index %0d is ready",
                     $time, late_idx);
        end
    endtask

    task automatic record_issue();
        int idx;
        idx = int'(issue.tag.rob_idx);
        if (slot_state[idx] == SLOT_PENDING) begin
            error_cnt++;
            $display("ROB index %0d issued again while still in flight", idx);
        end
        slot_state[idx] = SLOT_PENDING;
        exp_tag[idx]    = issue.tag;
        exp_val[idx]    = expected_result(issue.op, issue.rs1_v, issue.rs2_v);
        acc_cyc[idx]    = cyc;
        seen_issue      = 1'b1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            cyc          = 0;
            seen_issue   = 1'b0;
            mismatch_cnt = 0;
            error_cnt    = 0;
            end_done     = 1'b0;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slot_state[i] = SLOT_FREE;
            end
        end else begin
            cyc = cyc + 1;
            if (!seen_issue && (busy || cdb.valid)) begin
                error_cnt++;
                $display("busy or CDB valid high after reset before any issue at %0t", $time);
            end
            if (cdb.valid) begin
                check_beat();
            end else begin
                check_drain();
            end
            // flush kills everything still in flight
            if (flush) begin
                for (int i = 0; i < NUM_SLOTS; i++) begin
                    if (slot_state[i] == SLOT_PENDING) begin
                        slot_state[i] = SLOT_FREE;
                    end
                end
            end else if (issue_valid && !busy) begin
                record_issue();
            end
            if (end_check && !end_done) begin
                for (int i = 0; i < NUM_SLOTS; i++) begin
                    if (slot_state[i] == SLOT_PENDING) begin
                        error_cnt++;
                        $display("result for ROB index %0d was never delivered", i);
                    end
                end
                end_done = 1'b1;
            end
        end
        pending_cnt = 0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (slot_state[i] == SLOT_PENDING) begin
                pending_cnt++;
            end
        end
    end

endmodule : cdb_checker

//--- dv/div_cluster_tb.sv
`timescale 1ns/1ns

module div_cluster_tb
import rv32i_types::*;
();

    localparam int NUM_LANES  = 3;
    localparam int WAIT_LIMIT = 200;
    localparam int NUM_STIM   = 28;

    // kinds of table entry
    localparam logic [1:0] K_ISSUE = 2'd0;
    localparam logic [1:0] K_FLUSH = 2'd1;
    localparam logic [1:0] K_DRAIN = 2'd2;

    typedef struct packed {
        logic [1:0] kind;
        div_funct_t op;
        xlen_word_t rs1;
        xlen_word_t rs2;
    } stim_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        issue_valid;
    issue_pkt_t  issue;
    logic        flush;
    logic        busy;
    cdb_t        cdb;
    logic        end_check;
    logic        end_done;
    int          mismatch_cnt;
    int          error_cnt;
    int          pending_cnt;
    int          timeout_cnt;
    int unsigned lcg_state;
    int          rob_cnt;

    stim_t stim_table [NUM_STIM] = '{
        // ordinary results, enough back to back to raise busy
        '{K_ISSUE, DIV_OP_DIV,  32'd100,       32'd7},
        '{K_ISSUE, DIV_OP_DIV,  32'hffffff9c,  32'd7},
        '{K_ISSUE, DIV_OP_REM,  32'hffffff9c,  32'd7},
        '{K_ISSUE, DIV_OP_REM,  32'd100,       32'hfffffff9},
        '{K_ISSUE, DIV_OP_DIV,  32'd100,       32'hfffffff9},
        '{K_ISSUE, DIV_OP_DIVU, 32'hffffff9c,  32'd7},
        '{K_ISSUE, DIV_OP_REMU, 32'hffffff9c,  32'd7},
        '{K_ISSUE, DIV_OP_DIV,  32'hffffff9c,  32'hfffffff9},
        '{K_DRAIN, DIV_OP_DIV,  32'd0,         32'd0},
        // divide by zero and signed overflow
        '{K_ISSUE, DIV_OP_DIV,  32'h12345678,  32'd0},
        '{K_ISSUE, DIV_OP_DIVU, 32'd5,         32'd0},
        '{K_ISSUE, DIV_OP_REM,  32'hffffff9c,  32'd0},
        '{K_ISSUE, DIV_OP_REMU, 32'd7,         32'd0},
        '{K_ISSUE, DIV_OP_DIV,  32'h80000000,  32'hffffffff},
        '{K_ISSUE, DIV_OP_REM,  32'h80000000,  32'hffffffff},
        '{K_ISSUE, DIV_OP_DIVU, 32'h80000000,  32'hffffffff},
        '{K_ISSUE, DIV_OP_REMU, 32'hffffffff,  32'h80000000},
        '{K_DRAIN, DIV_OP_DIV,  32'd0,         32'd0},
        // flush with lanes running, packet offered in the flush cycle
        '{K_ISSUE, DIV_OP_DIV,  32'd1000,      32'd3},
        '{K_ISSUE, DIV_OP_REM,  32'hffff0000,  32'd13},
        '{K_FLUSH, DIV_OP_DIVU, 32'd77,        32'd5},
        '{K_ISSUE, DIV_OP_REM,  32'd1000,      32'd3},
        '{K_ISSUE, DIV_OP_DIVU, 32'hdeadbeef,  32'd10},
        '{K_DRAIN, DIV_OP_DIV,  32'd0,         32'd0},
        // all lanes busy, then drained by the arbiter
        '{K_ISSUE, DIV_OP_DIV,  32'h7fffffff,  32'd2},
        '{K_ISSUE, DIV_OP_REMU, 32'h00012345,  32'd100},
        '{K_ISSUE, DIV_OP_DIV,  32'h80000000,  32'd2},
        '{K_DRAIN, DIV_OP_DIV,  32'd0,         32'd0}
    };

    always #10 clk = ~clk;

    div_cluster #(
        .NUM_LANES   (NUM_LANES)
    ) div_cluster_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .flush       (flush),
        .busy        (busy),
        .cdb         (cdb)
    );

    cdb_checker cdb_checker_inst (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .flush        (flush),
        .busy         (busy),
        .cdb          (cdb),
        .end_check    (end_check),
        .mismatch_cnt (mismatch_cnt),
        .error_cnt    (error_cnt),
        .pending_cnt  (pending_cnt),
        .end_done     (end_done)
    );

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // ROB index is a running count, the register numbers are random
    function automatic issue_pkt_t build_packet(input stim_t s);
        issue_pkt_t pkt;
        lcg_state        = lcg_next(lcg_state);
        pkt.op           = s.op;
        pkt.rs1_v        = s.rs1;
        pkt.rs2_v        = s.rs2;
        pkt.tag.rob_idx  = rob_idx_t'(rob_cnt);
        pkt.tag.pd_s     = lcg_state[29:24];
        pkt.tag.rd_s     = lcg_state[20:16];
        rob_cnt++;
        return pkt;
    endfunction

    // hold the packet until an edge with busy low takes it
    task automatic send_packet(input issue_pkt_t pkt);
        int   waited;
        logic busy_seen;
        issue       <= pkt;
        issue_valid <= 1'b1;
        waited    = 0;
        busy_seen = 1'b1;
        while (busy_seen && waited < WAIT_LIMIT) begin
            @(negedge clk);
            busy_seen = busy;
            @(posedge clk);
            waited++;
        end
        if (busy_seen) begin
            $display("timeout: busy stayed high for %0d cycles", WAIT_LIMIT);
            timeout_cnt++;
        end
        issue_valid <= 1'b0;
    endtask

    task automatic flush_with_packet(input issue_pkt_t pkt);
        issue       <= pkt;
        issue_valid <= 1'b1;
        flush       <= 1'b1;
        @(posedge clk);
        issue_valid <= 1'b0;
        flush       <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        int pend;
        waited = 0;
        do begin
            @(negedge clk);
            pend = pending_cnt;
            waited++;
        end while (pend != 0 && waited < WAIT_LIMIT);
        if (pend != 0) begin
            $display("timeout: %0d results still outstanding after %0d cycles", pend, waited);
            timeout_cnt++;
        end
        @(posedge clk);
    endtask

    initial begin
        int waited;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        flush       = 1'b0;
        end_check   = 1'b0;
        timeout_cnt = 0;
        lcg_state   = 82;
        rob_cnt     = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // idle gap so the reset state is observed
        repeat (4) @(posedge clk);
        for (int i = 0; i < NUM_STIM; i++) begin
            if (timeout_cnt == 0) begin
                case (stim_table[i].kind)
                    K_ISSUE: send_packet(build_packet(stim_table[i]));
                    K_FLUSH: flush_with_packet(build_packet(stim_table[i]));
                    default: wait_drain();
                endcase
            end
        end
        end_check <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!end_done && waited < WAIT_LIMIT);
        if (!end_done) begin
            $display("timeout: end of run check never completed");
            timeout_cnt++;
        end
        $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
                 mismatch_cnt, error_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && error_cnt == 0 && timeout_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : div_cluster_tb

//--- list.f
verilog/rv32i_types.sv
verilog/issue_steer.sv
verilog/fu_div_rem.sv
verilog/cdb_arbiter.sv
verilog/div_cluster.sv
dv/cdb_checker.sv
dv/div_cluster_tb.sv

//--- run.sh
#!/bin/sh
# build and run the division cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module div_cluster_tb \
    -f list.f -o div_cluster_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/div_cluster_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- verilog/cdb_arbiter.sv
`timescale 1ns/1ns

module cdb_arbiter
import rv32i_types::*;
#(
    parameter int NUM_LANES = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic [NUM_LANES-1:0] lane_done,
    input  cdb_t                 lane_result [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_grant,
    output cdb_t                 cdb
);

    localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    // lane granted most recently
    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] sel;
    logic             any_req;

    // search starts one past the last winner and wraps
    always_comb begin
        int idx;

        sel        = last_q;
        any_req    = 1'b0;
        lane_grant = '0;
        for (int i = 1; i <= NUM_LANES; i++) begin
            idx = (int'(last_q) + i) % NUM_LANES;
            if (!any_req && lane_done[idx]) begin
                any_req = 1'b1;
                sel     = IDX_W'(idx);
            end
        end
        // no lane is released in a flush cycle
        if (any_req && !flush) begin
            lane_grant[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_q <= IDX_W'(NUM_LANES - 1);
        end else if (any_req && !flush) begin
            last_q <= sel;
        end
    end

    // registered CDB port, one beat per granted lane
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            cdb <= '0;
        end else if (any_req) begin
            cdb       <= lane_result[sel];
            cdb.valid <= 1'b1;
        end else begin
            cdb.valid <= 1'b0;
        end
    end

endmodule : cdb_arbiter

//--- verilog/div_cluster.sv
`timescale 1ns/1ns

module div_cluster
import rv32i_types::*;
#(
    parameter int NUM_LANES = 3
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_valid,
    input  issue_pkt_t issue,
    input  logic       flush,
    output logic       busy,
    output cdb_t       cdb
);

    // steering to lanes
    logic [NUM_LANES-1:0] lane_idle;
    logic [NUM_LANES-1:0] lane_start;

    // lanes to arbiter
    logic [NUM_LANES-1:0] lane_done;
    logic [NUM_LANES-1:0] lane_grant;
    cdb_t                 lane_result [NUM_LANES];

    issue_steer #(
        .NUM_LANES   (NUM_LANES)
    ) issue_steer_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .flush       (flush),
        .lane_idle   (lane_idle),
        .busy        (busy),
        .lane_start  (lane_start)
    );

    // the issue bus is shared; only the started lane captures it
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        fu_div_rem fu_div_rem_inst (
            .clk    (clk),
            .rst    (rst),
            .start  (lane_start[g]),
            .flush  (flush),
            .issue  (issue),
            .grant  (lane_grant[g]),
            .idle   (lane_idle[g]),
            .done   (lane_done[g]),
            .result (lane_result[g])
        );
    end

    cdb_arbiter #(
        .NUM_LANES   (NUM_LANES)
    ) cdb_arbiter_inst (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .lane_done   (lane_done),
        .lane_result (lane_result),
        .lane_grant  (lane_grant),
        .cdb         (cdb)
    );

endmodule : div_cluster

//--- verilog/fu_div_rem.sv
`timescale 1ns/1ns

module fu_div_rem
import rv32i_types::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       flush,
    input  issue_pkt_t issue,
    input  logic       grant,
    output logic       idle,
    output logic       done,
    output cdb_t       result
);

    localparam int CNT_W = $clog2(NUM_DIV_CYCLES + 1);
    // count value of the sign fix-up cycle
    localparam logic [CNT_W-1:0] FIXUP_CNT = CNT_W'(NUM_DIV_CYCLES);

    div_state_t       state;
    logic [CNT_W-1:0] iter_cnt;

    // operation captured at start
    res_tag_t   tag_q;
    logic       rem_op_q;
    logic       q_neg_q;
    logic       r_neg_q;
    xlen_word_t dvsr_q;

    // quo_q starts as the dividend and fills with quotient bits
    xlen_word_t quo_q;
    xlen_word_t rem_q;
    xlen_word_t rd_v_q;

    logic          signed_op;
    logic          rem_op;
    xlen_word_t    rs1_abs;
    xlen_word_t    rs2_abs;
    logic [XLEN:0] rem_shift;
    logic          sub_ok;
    xlen_word_t    rem_diff;

    // decode of the incoming operation
    assign signed_op = (issue.op == DIV_OP_DIV) || (issue.op == DIV_OP_REM);
    assign rem_op    = (issue.op == DIV_OP_REM) || (issue.op == DIV_OP_REMU);

    // magnitudes; the most negative value maps onto itself as unsigned
    assign rs1_abs = (signed_op && issue.rs1_v[XLEN-1]) ? -issue.rs1_v : issue.rs1_v;
    assign rs2_abs = (signed_op && issue.rs2_v[XLEN-1]) ? -issue.rs2_v : issue.rs2_v;

    // one restoring step
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign sub_ok    = (rem_shift >= {1'b0, dvsr_q});
    // true difference is below the divisor, so it fits one word
    assign rem_diff  = rem_shift[XLEN-1:0] - dvsr_q;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state    <= DIV_IDLE;
            iter_cnt <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state    <= DIV_RUN;
                        iter_cnt <= '0;
                    end
                end
                DIV_RUN: begin
                    if (iter_cnt == FIXUP_CNT) begin
                        state <= DIV_DONE;
                    end else begin
                        iter_cnt <= iter_cnt + 1'b1;
                    end
                end
                DIV_DONE: begin
                    // hold until the arbiter takes the result
                    if (grant) begin
                        state <= DIV_IDLE;
                    end
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            tag_q    <= issue.tag;
            rem_op_q <= rem_op;
            // divide by zero keeps the all-ones quotient unsigned
            q_neg_q  <= signed_op & (issue.rs1_v[XLEN-1] ^ issue.rs2_v[XLEN-1])
                        & (|issue.rs2_v);
            // remainder follows the dividend
            r_neg_q  <= signed_op & issue.rs1_v[XLEN-1];
            dvsr_q   <= rs2_abs;
            quo_q    <= rs1_abs;
            rem_q    <= '0;
        end else if (state == DIV_RUN) begin
            if (iter_cnt != FIXUP_CNT) begin
                quo_q <= {quo_q[XLEN-2:0], sub_ok};
                rem_q <= sub_ok ? rem_diff : rem_shift[XLEN-1:0];
            end else begin
                // sign fix-up
                // overflow (min / -1) gives quotient min and remainder 0 here
                if (rem_op_q) begin
                    rd_v_q <= r_neg_q ? -rem_q : rem_q;
                end else begin
                    rd_v_q <= q_neg_q ? -quo_q : quo_q;
                end
            end
        end
    end

    assign idle = (state == DIV_IDLE);
    assign done = (state == DIV_DONE);

    // valid is set by the arbiter when the beat is registered
    always_comb begin
        result       = '0;
        result.tag   = tag_q;
        result.rd_v  = rd_v_q;
    end

endmodule : fu_div_rem

//--- verilog/issue_steer.sv
`timescale 1ns/1ns

module issue_steer #(
    parameter int NUM_LANES = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  logic                 flush,
    input  logic [NUM_LANES-1:0] lane_idle,
    output logic                 busy,
    output logic [NUM_LANES-1:0] lane_start
);

    // start bits given on the last edge
    logic [NUM_LANES-1:0] start_q;
    logic [NUM_LANES-1:0] lane_free;
    logic [NUM_LANES-1:0] pick;
    logic                 accept;

    // a lane picked last cycle has its idle flag updated on that same
    // edge, so keep it out of the free set for one cycle
    assign lane_free = lane_idle & ~start_q;

    // back-pressure depends on lane state only
    assign busy = ~|lane_free;

    // packets offered during a flush are dropped
    assign accept = issue_valid & ~flush & ~busy;

    // lowest-numbered free lane, as a one-hot vector
    always_comb begin
        pick = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (lane_free[i]) begin
                pick    = '0;
                pick[i] = 1'b1;
            end
        end
    end

    assign lane_start = accept ? pick : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_q <= '0;
        end else begin
            start_q <= lane_start;
        end
    end

endmodule : issue_steer

//--- verilog/rv32i_types.sv
package rv32i_types;

    // datapath and tag widths
    localparam int XLEN           = 32;
    localparam int ROB_ADDR_WIDTH = 5;
    localparam int PHYS_REG_BITS  = 6;
    localparam int ARCH_REG_BITS  = 5;

    // quotient bits produced one per cycle
    localparam int NUM_DIV_CYCLES = 32;

    typedef logic [XLEN-1:0]           xlen_word_t;
    typedef logic [ROB_ADDR_WIDTH-1:0] rob_idx_t;
    typedef logic [PHYS_REG_BITS-1:0]  phys_reg_t;
    typedef logic [ARCH_REG_BITS-1:0]  arch_reg_t;

    // low two bits of funct3 for the M-extension divides
    typedef logic [1:0] div_funct_t;

    localparam div_funct_t DIV_OP_DIV  = 2'b00;
    localparam div_funct_t DIV_OP_DIVU = 2'b01;
    localparam div_funct_t DIV_OP_REM  = 2'b10;
    localparam div_funct_t DIV_OP_REMU = 2'b11;

    // where a result goes once it leaves the cluster
    typedef struct packed {
        rob_idx_t  rob_idx;
        phys_reg_t pd_s;
        arch_reg_t rd_s;
    } res_tag_t;

    // one packet from the issue port
    typedef struct packed {
        div_funct_t op;
        xlen_word_t rs1_v;
        xlen_word_t rs2_v;
        res_tag_t   tag;
    } issue_pkt_t;

    // common data bus beat
    typedef struct packed {
        logic       valid;
        res_tag_t   tag;
        xlen_word_t rd_v;
    } cdb_t;

    // lane FSM
    typedef enum logic [1:0] {
        DIV_IDLE = 2'b00,
        DIV_RUN  = 2'b01,
        DIV_DONE = 2'b10
    } div_state_t;

endpackage : rv32i_types
